//--- design/mipsControl.sv
`timescale 1ns/1ps

module mipsControl (
	input  logic                                 CLK,
	input  logic                                 reset,
	// Wishbone master
	input  logic [mipsCoreCfgPkg::DATA_W-1:0]    wbDatR,
	input  logic                                 wbAck,
	output logic                                 wbCyc,
	output logic                                 wbStb,
	output logic                                 wbWe,
	output logic [mipsCoreCfgPkg::ADDR_W-1:0]    wbAdr,
	output logic [mipsCoreCfgPkg::DATA_W-1:0]    wbDatW,
	// Datapath
	input  logic [mipsCoreCfgPkg::DATA_W-1:0]    aluResult,
	input  logic [mipsCoreCfgPkg::DATA_W-1:0]    rdDataB,
	input  logic [mipsCoreCfgPkg::DATA_W-1:0]    wrData,
	output mipsIsaPkg::instrWord_t               instr,
	output logic [mipsCoreCfgPkg::REG_AW-1:0]    rdAddrA,
	output logic [mipsCoreCfgPkg::REG_AW-1:0]    rdAddrB,
	output logic                                 wrEn,
	output logic [mipsCoreCfgPkg::REG_AW-1:0]    wrAddr,
	output logic [mipsCoreCfgPkg::DATA_W-1:0]    loadData,
	output logic                                 wbSel,
	// Retire
	output logic [mipsCoreCfgPkg::DATA_W-1:0]    dataOut,
	output logic                                 retired
);

	logic [2:0]                          state;
	logic [mipsCoreCfgPkg::ADDR_W-1:0]   pc;
	logic                                isStore;
	logic                                isLoad;
	logic                                isRType;
	logic                                busDone;

	////////////////////////////////////////////////////////////
	// Instruction field decode
	////////////////////////////////////////////////////////////

	assign isStore = (instr.i.opcode == mipsIsaPkg::OP_SW);
	assign isLoad  = (instr.i.opcode == mipsIsaPkg::OP_LW);
	assign isRType = (instr.i.opcode == mipsIsaPkg::OP_RTYPE);

	assign rdAddrA = instr.r.rs;	// Operand A / base
	assign rdAddrB = instr.r.rt;	// Operand B / store data
	assign wrAddr  = isRType ? instr.r.rd : instr.i.rt;	// rd for R, rt for I

	assign wrEn  = (state == mipsCoreCfgPkg::ST_WB);	// Only ALU ops and LW reach WB
	assign wbSel = isLoad;	// Load word goes to regfile

	assign busDone = wbStb & wbAck;	// Ack counts only inside a strobe

	////////////////////////////////////////////////////////////
	// Sequencer and Wishbone master
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		retired <= 1'b0;	// Single-cycle pulse by default
		if (reset) begin
			state   <= mipsCoreCfgPkg::ST_FETCH;
			pc      <= '0;
			wbCyc   <= 1'b0;
			wbStb   <= 1'b0;
			wbWe    <= 1'b0;
			dataOut <= '0;
		end else begin
			case (state)
				mipsCoreCfgPkg::ST_FETCH: begin
					if (busDone) begin
						instr <= wbDatR;	// Capture opcode word
						pc    <= pc + mipsCoreCfgPkg::PC_STEP;
						wbCyc <= 1'b0;	// Drop the cycle after ack
						wbStb <= 1'b0;
						state <= mipsCoreCfgPkg::ST_DECODE;
					end else if (!wbCyc) begin
						wbCyc <= 1'b1;	// Start read at PC
						wbStb <= 1'b1;
						wbWe  <= 1'b0;
						wbAdr <= pc;
					end
				end
				mipsCoreCfgPkg::ST_DECODE: begin
					// Register file reads land at the end of this cycle
					case (instr.i.opcode)
						mipsIsaPkg::OP_RTYPE,
						mipsIsaPkg::OP_ADDI,
						mipsIsaPkg::OP_SLTI,
						mipsIsaPkg::OP_ANDI,
						mipsIsaPkg::OP_ORI,
						mipsIsaPkg::OP_XORI,
						mipsIsaPkg::OP_LUI,
						mipsIsaPkg::OP_LW,
						mipsIsaPkg::OP_SW:
							state <= mipsCoreCfgPkg::ST_EXEC;
						default: begin
							// Unknown opcode, retire as no-op
							retired <= 1'b1;
							state   <= mipsCoreCfgPkg::ST_FETCH;
						end
					endcase
				end
				mipsCoreCfgPkg::ST_EXEC: begin
					if (isLoad || isStore)
						state <= mipsCoreCfgPkg::ST_MEM;	// Address in aluResult next
					else
						state <= mipsCoreCfgPkg::ST_WB;
				end
				mipsCoreCfgPkg::ST_MEM: begin
					if (busDone) begin
						wbCyc <= 1'b0;
						wbStb <= 1'b0;
						wbWe  <= 1'b0;
						if (isStore) begin
							retired <= 1'b1;	// Store done at ack
							dataOut <= wrData;	// Store address
							state   <= mipsCoreCfgPkg::ST_FETCH;
						end else begin
							loadData <= wbDatR;
							state    <= mipsCoreCfgPkg::ST_WB;
						end
					end else if (!wbCyc) begin
						wbCyc  <= 1'b1;	// Data cycle, held until ack
						wbStb  <= 1'b1;
						wbWe   <= isStore;
						wbAdr  <= aluResult[mipsCoreCfgPkg::ADDR_W-1:0];
						wbDatW <= rdDataB;	// rt value for SW
					end
				end
				mipsCoreCfgPkg::ST_WB: begin
					retired <= 1'b1;
					dataOut <= wrData;	// Same word the regfile takes
					state   <= mipsCoreCfgPkg::ST_FETCH;
				end
				default: state <= mipsCoreCfgPkg::ST_FETCH;
			endcase
		end
	end

endmodule

//--- design/mipsCore.sv
`timescale 1ns/1ps

module mipsCore (
	input  logic                                 CLK,
	input  logic                                 reset,
	// Wishbone master port
	input  logic [mipsCoreCfgPkg::DATA_W-1:0]    wbDatR,
	input  logic                                 wbAck,
	output logic                                 wbCyc,
	output logic                                 wbStb,
	output logic                                 wbWe,
	output logic [mipsCoreCfgPkg::ADDR_W-1:0]    wbAdr,
	output logic [mipsCoreCfgPkg::DATA_W-1:0]    wbDatW,
	// Retire
	output logic [mipsCoreCfgPkg::DATA_W-1:0]    dataOut,
	output logic                                 retired
);

	mipsIsaPkg::instrWord_t              instr;
	logic [mipsCoreCfgPkg::REG_AW-1:0]   rdAddrA;
	logic [mipsCoreCfgPkg::REG_AW-1:0]   rdAddrB;
	logic [mipsCoreCfgPkg::REG_AW-1:0]   wrAddr;
	logic                                wrEn;
	logic                                wbSel;
	logic [mipsCoreCfgPkg::DATA_W-1:0]   rdDataA;
	logic [mipsCoreCfgPkg::DATA_W-1:0]   rdDataB;
	logic [mipsCoreCfgPkg::DATA_W-1:0]   aluResult;
	logic [mipsCoreCfgPkg::DATA_W-1:0]   loadData;
	logic [mipsCoreCfgPkg::DATA_W-1:0]   wrData;

	// Write-back source, load word or ALU
	assign wrData = wbSel ? loadData : aluResult;

	////////////////////////////////////////////////////////////
	// Blocks
	////////////////////////////////////////////////////////////

	mipsControl uControl (
		.CLK(CLK), .reset(reset),
		.wbDatR(wbDatR), .wbAck(wbAck),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
		.wbAdr(wbAdr), .wbDatW(wbDatW),
		.aluResult(aluResult), .rdDataB(rdDataB), .wrData(wrData),
		.instr(instr), .rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
		.wrEn(wrEn), .wrAddr(wrAddr),
		.loadData(loadData), .wbSel(wbSel),
		.dataOut(dataOut), .retired(retired)
	);

	mipsRegFile uRegFile (
		.CLK(CLK), .reset(reset),
		.rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
		.wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
		.rdDataA(rdDataA), .rdDataB(rdDataB)
	);

	mipsExecute uExecute (
		.CLK(CLK), .reset(reset),
		.instr(instr),
		.rdDataA(rdDataA), .rdDataB(rdDataB),
		.aluResult(aluResult)
	);

endmodule

//--- design/mipsCoreCfgPkg.sv
package mipsCoreCfgPkg;

	////////////////////////////////////////////////////////////
	// Datapath sizes
	////////////////////////////////////////////////////////////

	localparam int DATA_W = 32;	// Word width
	localparam int ADDR_W = 9;	// Byte address, 512 B space
	localparam int REG_AW = 5;	// Register index
	localparam int REG_N  = 32;	// Register count

	// PC advance per instruction, one word
	localparam logic [ADDR_W-1:0] PC_STEP = 9'd4;

	////////////////////////////////////////////////////////////
	// Sequencer states
	////////////////////////////////////////////////////////////

	localparam logic [2:0] ST_FETCH  = 3'd0;	// Instruction bus cycle
	localparam logic [2:0] ST_DECODE = 3'd1;	// Register read
	localparam logic [2:0] ST_EXEC   = 3'd2;	// ALU
	localparam logic [2:0] ST_MEM    = 3'd3;	// Data bus cycle
	localparam logic [2:0] ST_WB     = 3'd4;	// Register write and retire

endpackage

//--- design/mipsExecute.sv
`timescale 1ns/1ps

module mipsExecute (
	input  logic                                 CLK,
	input  logic                                 reset,
	input  mipsIsaPkg::instrWord_t               instr,
	input  logic [mipsCoreCfgPkg::DATA_W-1:0]    rdDataA,
	input  logic [mipsCoreCfgPkg::DATA_W-1:0]    rdDataB,
	output logic [mipsCoreCfgPkg::DATA_W-1:0]    aluResult
);

	logic [2:0]                          aluOp;
	logic [mipsCoreCfgPkg::DATA_W-1:0]   opA;
	logic [mipsCoreCfgPkg::DATA_W-1:0]   opB;
	logic [mipsCoreCfgPkg::DATA_W-1:0]   immSext;
	logic [mipsCoreCfgPkg::DATA_W-1:0]   immZext;
	logic [mipsCoreCfgPkg::DATA_W-1:0]   immUpper;
	logic [mipsCoreCfgPkg::DATA_W-1:0]   aluNext;
	logic                                isLui;

	////////////////////////////////////////////////////////////
	// Immediate forms
	////////////////////////////////////////////////////////////

	assign immSext  = {{(mipsCoreCfgPkg::DATA_W-16){instr.i.imm16[15]}}, instr.i.imm16};
	assign immZext  = {{(mipsCoreCfgPkg::DATA_W-16){1'b0}}, instr.i.imm16};
	assign immUpper = {instr.i.imm16, {(mipsCoreCfgPkg::DATA_W-16){1'b0}}};	// LUI

	assign isLui = (instr.i.opcode == mipsIsaPkg::OP_LUI);
	assign opA   = isLui ? '0 : rdDataA;	// LUI ignores rs

	// Operand B select and ALU op decode
	always_comb begin
		opB   = immSext;	// ADDI, SLTI, LW, SW
		aluOp = mipsIsaPkg::ALU_ADD;
		case (instr.i.opcode)
			mipsIsaPkg::OP_RTYPE: begin
				opB = rdDataB;
				case (instr.r.funct)
					mipsIsaPkg::FN_SUB:  aluOp = mipsIsaPkg::ALU_SUB;
					mipsIsaPkg::FN_AND:  aluOp = mipsIsaPkg::ALU_AND;
					mipsIsaPkg::FN_OR:   aluOp = mipsIsaPkg::ALU_OR;
					mipsIsaPkg::FN_XOR:  aluOp = mipsIsaPkg::ALU_XOR;
					mipsIsaPkg::FN_NOR:  aluOp = mipsIsaPkg::ALU_NOR;
					mipsIsaPkg::FN_SLT:  aluOp = mipsIsaPkg::ALU_SLT;
					mipsIsaPkg::FN_SLTU: aluOp = mipsIsaPkg::ALU_SLTU;
					default:             aluOp = mipsIsaPkg::ALU_ADD;	// FN_ADD too
				endcase
			end
			mipsIsaPkg::OP_SLTI: aluOp = mipsIsaPkg::ALU_SLT;
			mipsIsaPkg::OP_ANDI: begin
				opB   = immZext;
				aluOp = mipsIsaPkg::ALU_AND;
			end
			mipsIsaPkg::OP_ORI: begin
				opB   = immZext;
				aluOp = mipsIsaPkg::ALU_OR;
			end
			mipsIsaPkg::OP_XORI: begin
				opB   = immZext;
				aluOp = mipsIsaPkg::ALU_XOR;
			end
			mipsIsaPkg::OP_LUI: begin
				opB   = immUpper;
				aluOp = mipsIsaPkg::ALU_OR;	// 0 | upper
			end
			default: aluOp = mipsIsaPkg::ALU_ADD;	// ADDI and address calc
		endcase
	end

	////////////////////////////////////////////////////////////
	// ALU
	////////////////////////////////////////////////////////////

	always_comb begin
		case (aluOp)
			mipsIsaPkg::ALU_SUB:  aluNext = opA - opB;
			mipsIsaPkg::ALU_AND:  aluNext = opA & opB;
			mipsIsaPkg::ALU_OR:   aluNext = opA | opB;
			mipsIsaPkg::ALU_XOR:  aluNext = opA ^ opB;
			mipsIsaPkg::ALU_NOR:  aluNext = ~(opA | opB);
			mipsIsaPkg::ALU_SLT:
				aluNext = {{(mipsCoreCfgPkg::DATA_W-1){1'b0}}, $signed(opA) < $signed(opB)};
			mipsIsaPkg::ALU_SLTU:
				aluNext = {{(mipsCoreCfgPkg::DATA_W-1){1'b0}}, opA < opB};
			default:              aluNext = opA + opB;	// No carry or overflow kept
		endcase
	end

	// Result register, refreshed every clock
	always_ff @(posedge CLK) begin
		if (reset)
			aluResult <= '0;
		else
			aluResult <= aluNext;
	end

endmodule

//--- design/mipsIsaPkg.sv
package mipsIsaPkg;

	////////////////////////////////////////////////////////////
	// Opcodes (instr[31:26])
	////////////////////////////////////////////////////////////

	localparam logic [5:0] OP_RTYPE = 6'b000000;	// ALU op picked by funct
	localparam logic [5:0] OP_ADDI  = 6'b001000;	// Sign-extended imm
	localparam logic [5:0] OP_SLTI  = 6'b001010;	// Signed compare with imm
	localparam logic [5:0] OP_ANDI  = 6'b001100;	// Zero-extended imm
	localparam logic [5:0] OP_ORI   = 6'b001101;	// Zero-extended imm
	localparam logic [5:0] OP_XORI  = 6'b001110;	// Zero-extended imm
	localparam logic [5:0] OP_LUI   = 6'b001111;	// imm into upper half
	localparam logic [5:0] OP_LW    = 6'b100011;	// Word load
	localparam logic [5:0] OP_SW    = 6'b101011;	// Word store

	////////////////////////////////////////////////////////////
	// R-type funct codes (instr[5:0])
	////////////////////////////////////////////////////////////

	localparam logic [5:0] FN_ADD  = 6'b100000;
	localparam logic [5:0] FN_SUB  = 6'b100010;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_XOR  = 6'b100110;
	localparam logic [5:0] FN_NOR  = 6'b100111;
	localparam logic [5:0] FN_SLT  = 6'b101010;	// Signed
	localparam logic [5:0] FN_SLTU = 6'b101011;	// Unsigned

	////////////////////////////////////////////////////////////
	// ALU operation codes, internal to the execute unit
	////////////////////////////////////////////////////////////

	localparam logic [2:0] ALU_ADD  = 3'd0;
	localparam logic [2:0] ALU_SUB  = 3'd1;
	localparam logic [2:0] ALU_AND  = 3'd2;
	localparam logic [2:0] ALU_OR   = 3'd3;	// Also passes LUI operand
	localparam logic [2:0] ALU_XOR  = 3'd4;
	localparam logic [2:0] ALU_NOR  = 3'd5;
	localparam logic [2:0] ALU_SLT  = 3'd6;
	localparam logic [2:0] ALU_SLTU = 3'd7;

	// Instruction word, same 32 bits seen as R or I format
	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			logic [4:0] rs;		// Source A
			logic [4:0] rt;		// Source B
			logic [4:0] rd;		// Destination
			logic [4:0] shamt;	// Unused, no shifts
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0]  opcode;
			logic [4:0]  rs;	// Base or source A
			logic [4:0]  rt;	// Destination, or store data
			logic [15:0] imm16;
		} i;
	} instrWord_t;

endpackage

//--- design/mipsRegFile.sv
`timescale 1ns/1ps

module mipsRegFile (
	input  logic                                 CLK,
	input  logic                                 reset,
	input  logic [mipsCoreCfgPkg::REG_AW-1:0]    rdAddrA,
	input  logic [mipsCoreCfgPkg::REG_AW-1:0]    rdAddrB,
	input  logic                                 wrEn,
	input  logic [mipsCoreCfgPkg::REG_AW-1:0]    wrAddr,
	input  logic [mipsCoreCfgPkg::DATA_W-1:0]    wrData,
	output logic [mipsCoreCfgPkg::DATA_W-1:0]    rdDataA,
	output logic [mipsCoreCfgPkg::DATA_W-1:0]    rdDataB
);

	logic [mipsCoreCfgPkg::DATA_W-1:0] regs [mipsCoreCfgPkg::REG_N];

	// Write port, r0 stays zero
	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < mipsCoreCfgPkg::REG_N; i++) begin
				regs[i] <= '0;	// Whole file starts cleared
			end
		end else if (wrEn && (wrAddr != '0)) begin
			regs[wrAddr] <= wrData;
		end
	end

	// Registered read ports, old value on same-cycle write
	always_ff @(posedge CLK) begin
		if (reset) begin
			rdDataA <= '0;
			rdDataB <= '0;
		end else begin
			rdDataA <= regs[rdAddrA];
			rdDataB <= regs[rdAddrB];
		end
	end

endmodule

//--- mipsCore.f
design/mipsIsaPkg.sv
design/mipsCoreCfgPkg.sv
design/mipsControl.sv
design/mipsRegFile.sv
design/mipsExecute.sv
design/mipsCore.sv
test/tbClockGen.sv
test/mipsWbMemory.sv
test/mipsCore_chk.sv
test/mipsCoreTb.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mipsCoreTb \
	-f mipsCore.f --Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/simv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "Done: no errors"; then
	exit 0
else
	exit 1
fi

//--- test/mipsCoreTb.sv
`timescale 1ns/1ps

module mipsCoreTb;

	localparam int         TIMEOUT  = 3000;	// Cycles to reach the sentinel
	localparam logic [8:0] SENTINEL = 9'd100;	// Word after the last instruction

	logic        CLK;
	logic        reset;
	logic        wbCyc;
	logic        wbStb;
	logic        wbWe;
	logic [8:0]  wbAdr;
	logic [31:0] wbDatW;
	logic [31:0] wbDatR;
	logic        wbAck;
	logic [31:0] dataOut;
	logic        retired;
	int          seed;
	int          timeoutCount;
	int          cycles;
	logic        found;

	tbClockGen uClk (.CLK(CLK), .reset(reset));

	mipsCore u_dut (
		.CLK(CLK), .reset(reset),
		.wbDatR(wbDatR), .wbAck(wbAck),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
		.wbAdr(wbAdr), .wbDatW(wbDatW),
		.dataOut(dataOut), .retired(retired)
	);

	mipsWbMemory uMem (
		.CLK(CLK), .reset(reset),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
		.wbAdr(wbAdr), .wbDatW(wbDatW),
		.wbDatR(wbDatR), .wbAck(wbAck)
	);

	function automatic logic [31:0] encR(input int rs, input int rt, input int rd,
		input logic [5:0] fn);
		encR = {mipsIsaPkg::OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
	endfunction

	function automatic logic [31:0] encI(input logic [5:0] op, input int rs, input int rt,
		input logic [15:0] imm);
		encI = {op, rs[4:0], rt[4:0], imm};
	endfunction

	////////////////////////////////////////////////////////////
	// Program
	////////////////////////////////////////////////////////////

	task automatic loadProgram();
		logic [15:0] immA;
		logic [15:0] immB;
		logic [15:0] immC;
		logic [15:0] immD;
		immA = 16'($random(seed));
		immB = 16'($random(seed));
		immC = 16'($random(seed));
		immD = 16'($random(seed));
		for (int i = 0; i < 128; i++) begin
			uMem.mem[i] = '0;
		end
		uMem.mem[0]  = encI(mipsIsaPkg::OP_ADDI, 0, 1, immA);
		uMem.mem[1]  = encI(mipsIsaPkg::OP_ADDI, 0, 2, immB | 16'h8000);	// Negative
		uMem.mem[2]  = encI(mipsIsaPkg::OP_ORI, 0, 3, immC | 16'h8000);	// Zero-extended
		uMem.mem[3]  = encR(1, 2, 4, mipsIsaPkg::FN_ADD);
		uMem.mem[4]  = encR(1, 2, 5, mipsIsaPkg::FN_SUB);
		uMem.mem[5]  = encR(1, 3, 6, mipsIsaPkg::FN_AND);
		uMem.mem[6]  = encR(2, 3, 7, mipsIsaPkg::FN_OR);
		uMem.mem[7]  = encR(1, 2, 8, mipsIsaPkg::FN_XOR);
		uMem.mem[8]  = encR(2, 3, 9, mipsIsaPkg::FN_NOR);
		uMem.mem[9]  = encR(2, 1, 10, mipsIsaPkg::FN_SLT);
		uMem.mem[10] = encR(2, 1, 11, mipsIsaPkg::FN_SLTU);
		uMem.mem[11] = encI(mipsIsaPkg::OP_ANDI, 2, 12, 16'hF0F0);
		uMem.mem[12] = encI(mipsIsaPkg::OP_XORI, 2, 13, 16'h8001);
		uMem.mem[13] = encI(mipsIsaPkg::OP_SLTI, 2, 14, 16'hFFFB);	// -5
		uMem.mem[14] = encI(mipsIsaPkg::OP_LUI, 2, 15, 16'h8765);	// rs field ignored
		uMem.mem[15] = encI(mipsIsaPkg::OP_ORI, 15, 15, immD);
		uMem.mem[16] = encI(mipsIsaPkg::OP_SW, 0, 4, 16'h0100);
		uMem.mem[17] = encI(mipsIsaPkg::OP_ADDI, 0, 16, 16'h0100);	// Base register
		uMem.mem[18] = encI(mipsIsaPkg::OP_SW, 16, 15, 16'h0008);
		uMem.mem[19] = encI(mipsIsaPkg::OP_LW, 16, 17, 16'h0000);
		uMem.mem[20] = encI(mipsIsaPkg::OP_LW, 16, 18, 16'h0008);
		uMem.mem[21] = encR(17, 18, 19, mipsIsaPkg::FN_ADD);	// Uses both loads
		uMem.mem[22] = encI(mipsIsaPkg::OP_ADDI, 1, 0, 16'd123);	// Targets r0
		uMem.mem[23] = encR(0, 0, 20, mipsIsaPkg::FN_ADD);
		uMem.mem[24] = encR(0, 3, 21, mipsIsaPkg::FN_OR);
	endtask

	////////////////////////////////////////////////////////////
	// Run and summary
	////////////////////////////////////////////////////////////

	initial begin
		seed         = 32'h4b88_2c7a;
		timeoutCount = 0;
		cycles       = 0;
		found        = 1'b0;
		loadProgram();
		while (!found && cycles < TIMEOUT) begin
			@(posedge CLK);
			#1;
			if (!reset && wbStb && !wbWe && wbAdr == SENTINEL)
				found = 1'b1;
			cycles++;
		end
		if (!found) begin
			timeoutCount++;
			$display("Timeout: the sentinel address was never fetched");
		end
		repeat (2) @(posedge CLK);
		$display("errors=%0d timeouts=%0d", u_dut.uChk.errCount, timeoutCount);
		if (u_dut.uChk.errCount == 0 && timeoutCount == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

//--- test/mipsCore_chk.sv
`timescale 1ns/1ps

module mipsCore_chk (
	input logic                                 CLK,
	input logic                                 reset,
	input logic                                 wbCyc,
	input logic                                 wbStb,
	input logic                                 wbWe,
	input logic [mipsCoreCfgPkg::ADDR_W-1:0]    wbAdr,
	input logic [mipsCoreCfgPkg::DATA_W-1:0]    wbDatW,
	input logic [mipsCoreCfgPkg::DATA_W-1:0]    wbDatR,
	input logic                                 wbAck,
	input logic [mipsCoreCfgPkg::DATA_W-1:0]    dataOut,
	input logic                                 retired
);

	int errCount = 0;	// Read by the testbench top

	logic [31:0]             shReg [32];	// Shadow register file
	logic [31:0]             shMem [128];	// Shadow data memory
	mipsIsaPkg::instrWord_t  curInstr;	// Word of the instruction in flight
	logic                    expectFetch;	// Next bus cycle is a fetch
	logic [8:0]              expFetchAdr;	// Where the next fetch must go
	logic                    retirePending;	// Fetched but not yet retired
	logic                    fetchAck;
	logic                    dataAck;
	logic [31:0]             opA;
	logic [31:0]             opB;
	logic [31:0]             sext;
	logic [31:0]             zext;
	logic [31:0]             memAddr;
	logic [31:0]             expVal;
	logic                    checkable;	// Retire has a known result
	logic                    writesReg;
	logic [4:0]              dest;
	logic                    isStore;

	assign fetchAck = wbStb && wbAck && expectFetch;
	assign dataAck  = wbStb && wbAck && !expectFetch;

	////////////////////////////////////////////////////////////
	// Shadow ISA model
	////////////////////////////////////////////////////////////

	assign opA     = shReg[curInstr.i.rs];
	assign opB     = shReg[curInstr.i.rt];
	assign sext    = {{16{curInstr.i.imm16[15]}}, curInstr.i.imm16};
	assign zext    = {16'h0000, curInstr.i.imm16};
	assign memAddr = opA + sext;	// Base plus offset
	assign isStore = (curInstr.i.opcode == mipsIsaPkg::OP_SW);
	assign dest    = (curInstr.i.opcode == mipsIsaPkg::OP_RTYPE) ? curInstr.r.rd : curInstr.i.rt;

	always_comb begin
		expVal    = '0;
		checkable = 1'b1;
		writesReg = 1'b1;
		case (curInstr.i.opcode)
			mipsIsaPkg::OP_RTYPE: begin
				case (curInstr.r.funct)
					mipsIsaPkg::FN_ADD:  expVal = opA + opB;
					mipsIsaPkg::FN_SUB:  expVal = opA - opB;
					mipsIsaPkg::FN_AND:  expVal = opA & opB;
					mipsIsaPkg::FN_OR:   expVal = opA | opB;
					mipsIsaPkg::FN_XOR:  expVal = opA ^ opB;
					mipsIsaPkg::FN_NOR:  expVal = ~(opA | opB);
					mipsIsaPkg::FN_SLT:  expVal = {31'd0, $signed(opA) < $signed(opB)};
					mipsIsaPkg::FN_SLTU: expVal = {31'd0, opA < opB};
					default:             checkable = 1'b0;	// Not in program
				endcase
			end
			mipsIsaPkg::OP_ADDI: expVal = opA + sext;
			mipsIsaPkg::OP_SLTI: expVal = {31'd0, $signed(opA) < $signed(sext)};
			mipsIsaPkg::OP_ANDI: expVal = opA & zext;
			mipsIsaPkg::OP_ORI:  expVal = opA | zext;
			mipsIsaPkg::OP_XORI: expVal = opA ^ zext;
			mipsIsaPkg::OP_LUI:  expVal = {curInstr.i.imm16, 16'h0000};
			mipsIsaPkg::OP_LW:   expVal = shMem[memAddr[8:2]];
			mipsIsaPkg::OP_SW: begin
				expVal    = memAddr;	// Store address shown at retire
				writesReg = 1'b0;
			end
			default: begin
				checkable = 1'b0;	// No-op leaves dataOut as is
				writesReg = 1'b0;
			end
		endcase
	end

	// Tracks bus phase and retires
	always_ff @(posedge CLK) begin
		if (reset) begin
			expectFetch   <= 1'b1;
			expFetchAdr   <= 9'd0;
			retirePending <= 1'b0;
			for (int i = 0; i < 32; i++) begin
				shReg[i] <= '0;
			end
			for (int i = 0; i < 128; i++) begin
				shMem[i] <= '0;
			end
		end else begin
			if (fetchAck) begin
				curInstr      <= wbDatR;
				expFetchAdr   <= expFetchAdr + 9'd4;	// Sequential program order
				retirePending <= 1'b1;
				if (wbDatR[31:26] == mipsIsaPkg::OP_LW || wbDatR[31:26] == mipsIsaPkg::OP_SW)
					expectFetch <= 1'b0;	// Data cycle comes next
			end
			if (dataAck)
				expectFetch <= 1'b1;
			if (retired) begin
				retirePending <= 1'b0;
				if (writesReg && dest != 5'd0)
					shReg[dest] <= expVal;	// r0 never written
				if (isStore)
					shMem[memAddr[8:2]] <= opB;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Bus protocol
	////////////////////////////////////////////////////////////

	aResetQuiet: assert property (@(posedge CLK) $past(reset) |-> (!wbCyc && !wbStb && !retired))
		else begin
			errCount++;
			$error("Bus strobes or retired high in the reset cycle");
		end

	aStbInCyc: assert property (@(posedge CLK) disable iff (reset) wbStb |-> wbCyc)
		else begin
			errCount++;
			$error("wbStb high without wbCyc");
		end

	aHold: assert property (@(posedge CLK) disable iff (reset)
		(wbStb && !wbAck) |=> (wbStb && $stable(wbAdr) && $stable(wbWe) && $stable(wbDatW)))
		else begin
			errCount++;
			$error("Bus request changed before ack");
		end

	aFetchAdr: assert property (@(posedge CLK) disable iff (reset)
		(wbStb && expectFetch) |-> (wbAdr == expFetchAdr))
		else begin
			errCount++;
			$error("FAILED %0t wbAdr exp=%h got=%h", $time,
				$sampled(expFetchAdr), $sampled(wbAdr));
		end

	////////////////////////////////////////////////////////////
	// Data cycles and results
	////////////////////////////////////////////////////////////

	aStoreAdr: assert property (@(posedge CLK) disable iff (reset)
		(wbStb && !expectFetch && isStore) |-> (wbWe && wbAdr == memAddr[8:0]))
		else begin
			errCount++;
			$error("FAILED %0t wbAdr exp=%h got=%h", $time,
				$sampled(memAddr[8:0]), $sampled(wbAdr));
		end

	aStoreData: assert property (@(posedge CLK) disable iff (reset)
		(wbStb && !expectFetch && isStore) |-> (wbDatW == opB))
		else begin
			errCount++;
			$error("FAILED %0t wbDatW exp=%h got=%h", $time, $sampled(opB), $sampled(wbDatW));
		end

	aLoadRead: assert property (@(posedge CLK) disable iff (reset)
		(wbStb && !expectFetch && !isStore) |-> !wbWe)
		else begin
			errCount++;
			$error("Load cycle issued as a write");
		end

	aRetireOnce: assert property (@(posedge CLK) disable iff (reset)
		retired |-> retirePending)
		else begin
			errCount++;
			$error("retired pulsed with no instruction in flight");
		end

	aRetireFirst: assert property (@(posedge CLK) disable iff (reset)
		(wbStb && expectFetch) |-> !retirePending)
		else begin
			errCount++;
			$error("Fetch started before the previous instruction retired");
		end

	aRetire: assert property (@(posedge CLK) disable iff (reset)
		(retired && checkable) |-> (dataOut == expVal))
		else begin
			errCount++;
			$error("FAILED %0t dataOut exp=%h got=%h", $time, $sampled(expVal), $sampled(dataOut));
		end

endmodule

bind mipsCore mipsCore_chk uChk (.*);

//--- test/mipsWbMemory.sv
`timescale 1ns/1ps

module mipsWbMemory (
	input  logic                                 CLK,
	input  logic                                 reset,
	input  logic                                 wbCyc,
	input  logic                                 wbStb,
	input  logic                                 wbWe,
	input  logic [mipsCoreCfgPkg::ADDR_W-1:0]    wbAdr,
	input  logic [mipsCoreCfgPkg::DATA_W-1:0]    wbDatW,
	output logic [mipsCoreCfgPkg::DATA_W-1:0]    wbDatR,
	output logic                                 wbAck
);

	logic [mipsCoreCfgPkg::DATA_W-1:0] mem [128];	// Word array, loaded by the testbench
	int waitLeft;	// -1 when no cycle is being served
	int waitSeed;

	initial begin
		wbDatR   = '0;
		wbAck    = 1'b0;
		waitLeft = -1;
		waitSeed = 32'h4b88_2c7a;
	end

	// Slave outputs change 1 ns after the edge
	always @(posedge CLK) begin
		#1;
		if (reset) begin
			wbAck    = 1'b0;
			waitLeft = -1;
		end else if (wbAck) begin
			wbAck = 1'b0;	// Master drops strobe at the ack edge
		end else if (wbCyc && wbStb) begin
			if (waitLeft < 0)
				waitLeft = $random(waitSeed) & 3;	// 0 to 3 wait states
			if (waitLeft == 0) begin
				if (wbWe)
					mem[wbAdr[8:2]] = wbDatW;
				wbDatR   = mem[wbAdr[8:2]];
				wbAck    = 1'b1;
				waitLeft = -1;
			end else begin
				waitLeft = waitLeft - 1;
			end
		end
	end

endmodule

//--- test/tbClockGen.sv
`timescale 1ns/1ps

module tbClockGen (
	output logic CLK,
	output logic reset
);

	// 4 ns period, reset held for two rising edges
	initial begin
		CLK   = 1'b0;
		reset = 1'b1;
		forever #2 CLK = ~CLK;
	end

	initial begin
		repeat (2) @(posedge CLK);
		#1 reset = 1'b0;	// Released off the edge
	end

endmodule
